//--- Makefile
# Verilator build and run of the packer testbench

VERILATOR  ?= verilator
TOP        ?= packTb
LINT_TOP   ?= packTop
FLIST      ?= packer.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: run build lint clean

run: build
	./$(OBJ_DIR)/V$(TOP)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- packer.f
source/busPkg.sv
source/packPkg.sv
source/apbRegs.sv
source/wordBuffer.sv
source/wordPacker.sv
source/packOutput.sv
source/packTop.sv
sim/packTb.sv

//--- sim/packTb.sv
// Directed tests of packTop; stops at the first mismatch and expects outReady high outside backPressure
module packTb;
    import busPkg::*;
    import packPkg::*;

    localparam int apbTimeout = 16;     // Cycles to wait for pready
    localparam int pktTimeout = 64;     // Cycles to wait for outValid

    logic    clk;
    logic    rst_n;
    logic    psel;
    logic    penable;
    logic    pwrite;
    apbAddr  paddr;
    apbData  pwdata;
    apbData  prdata;
    logic    pready;
    logic    pslverr;
    logic    outValid;
    logic    outReady;
    packetT  outPacket;

    string   testName;
    integer  seed;
    dataWord words [numWords];  // Host copy of the buffer

    packTop UUT (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .outValid(outValid), .outReady(outReady), .outPacket(outPacket)
    );

    always #20 clk = ~clk;  // Period 40

    // ==========================================================
    // Failure reporting and typed compares
    // ==========================================================
    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkData(input string what, input apbData exp, input apbData act);
        if (exp !== act) begin
            reportFailure($sformatf("ERROR %s %s: expected %h, actual %h",
                                    testName, what, exp, act));
        end
    endtask

    task automatic checkPacket(input string what, input packetT exp, input packetT act);
        if (exp !== act) begin
            reportFailure($sformatf("ERROR %s %s: expected %h/%0d, actual %h/%0d",
                                    testName, what, exp.data, exp.count, act.data, act.count));
        end
    endtask

    task automatic checkFlag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            reportFailure($sformatf("ERROR %s %s: expected %b, actual %b",
                                    testName, what, exp, act));
        end
    endtask

    // ==========================================================
    // Reference model and register words
    // ==========================================================
    // Word i lands at word slot cnt-i, so word 0 is highest
    function automatic packetT expectPacket(input wordCount cnt);
        packetT pkt;
        pkt.data  = '0;
        pkt.count = cnt;
        for (int i = 0; i <= int'(cnt); i++) begin
            pkt.data = pkt.data | (packWord'(words[i]) << ((int'(cnt) - i) * wordWidth));
        end
        return pkt;
    endfunction

    function automatic apbData ctrlWord(input logic startCmd, input logic bypassCmd);
        apbData w;
        w                = '0;
        w[ctrlStartBit]  = startCmd;
        w[ctrlBypassBit] = bypassCmd;
        return w;
    endfunction

    function automatic apbData statusWord(input logic busyFlag);
        apbData w;
        w                = '0;
        w[statusBusyBit] = busyFlag;
        return w;
    endfunction

    // ==========================================================
    // APB driver and stream wait
    // ==========================================================
    task automatic busCycle(input logic write, input apbAddr addr, input apbData wdata,
                            output apbData rdata, output logic err);
        int waitCycles;
        @(posedge clk);     // Setup phase
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);     // Access phase
        penable <= 1'b1;
        waitCycles = 0;
        @(negedge clk);
        while (!pready) begin
            if (waitCycles == apbTimeout) begin
                reportFailure($sformatf("%s: APB access never saw pready", testName));
            end else begin
                waitCycles++;
                @(negedge clk);
            end
        end
        rdata = prdata;     // Mid-cycle sample
        err   = pslverr;
        @(posedge clk);     // Write lands here
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apbWrite(input apbAddr addr, input apbData data, input logic expErr);
        apbData rd;
        logic   err;
        busCycle(1'b1, addr, data, rd, err);
        checkFlag("write pslverr", expErr, err);
    endtask

    task automatic apbRead(input apbAddr addr, output apbData data, input logic expErr);
        logic err;
        busCycle(1'b0, addr, '0, data, err);
        checkFlag("read pslverr", expErr, err);
    endtask

    // Returns on the edge that transfers when outReady is high
    task automatic waitPacket(output packetT pkt);
        int waitCycles;
        waitCycles = 0;
        @(negedge clk);
        while (!outValid) begin
            if (waitCycles == pktTimeout) begin
                reportFailure($sformatf("%s: no packet appeared on the output stream",
                                        testName));
            end else begin
                waitCycles++;
                @(negedge clk);
            end
        end
        pkt = outPacket;
        @(posedge clk);
    endtask

    // ==========================================================
    // Tests
    // ==========================================================
    task automatic resetState();
        testName = "resetState";
        @(negedge clk);
        checkFlag("outValid", 1'b0, outValid);
        checkFlag("pslverr", 1'b0, pslverr);
        checkFlag("pready", 1'b1, pready);
    endtask

    task automatic fullPacket();
        packetT pkt;
        testName = "fullPacket";
        for (int i = 0; i < numWords; i++) begin
            apbWrite(apbAddr'(regWordBase + 4 * i), apbData'(words[i]), 1'b0);
        end
        apbWrite(regCount, apbData'(7), 1'b0);
        apbWrite(regCtrl, ctrlWord(1'b1, 1'b0), 1'b0);
        waitPacket(pkt);
        checkPacket("packet", expectPacket(wordCount'(7)), pkt);
    endtask

    task automatic shortPacket();
        packetT pkt;
        testName = "shortPacket";
        apbWrite(regCount, apbData'(2), 1'b0);  // Three words
        apbWrite(regCtrl, ctrlWord(1'b1, 1'b0), 1'b0);
        waitPacket(pkt);
        checkPacket("packet", expectPacket(wordCount'(2)), pkt);
    endtask

    task automatic bypassPacket();
        packetT pkt;
        testName = "bypassPacket";
        apbWrite(regCtrl, ctrlWord(1'b0, 1'b1), 1'b0);
        waitPacket(pkt);
        checkPacket("bypass", '0, pkt);
        apbWrite(regCtrl, ctrlWord(1'b1, 1'b1), 1'b0);     // Bypass wins
        waitPacket(pkt);
        checkPacket("start with bypass", '0, pkt);
        apbWrite(regCtrl, ctrlWord(1'b1, 1'b0), 1'b0);     // Buffer untouched
        waitPacket(pkt);
        checkPacket("start after bypass", expectPacket(wordCount'(2)), pkt);
    endtask

    task automatic backPressure();
        packetT held;
        packetT expPkt;
        apbData rd;
        int     delivered;
        testName = "backPressure";
        expPkt   = expectPacket(wordCount'(7));
        @(posedge clk);
        outReady <= 1'b0;
        apbWrite(regCount, apbData'(7), 1'b0);
        apbWrite(regCtrl, ctrlWord(1'b1, 1'b0), 1'b0);
        waitPacket(held);
        checkPacket("held packet", expPkt, held);
        repeat (6) begin
            @(negedge clk);
            checkFlag("outValid stalled", 1'b1, outValid);
            checkPacket("stalled packet", expPkt, outPacket);
        end
        apbRead(regStatus, rd, 1'b0);
        checkData("STATUS stalled", statusWord(1'b1), rd);
        apbWrite(regCount, apbData'(1), 1'b0);
        apbWrite(regCtrl, ctrlWord(1'b1, 1'b0), 1'b0);     // Must be dropped
        delivered = 0;
        @(posedge clk);
        outReady <= 1'b1;
        repeat (12) begin
            @(negedge clk);
            if (outValid) begin
                delivered++;
                checkPacket("released packet", expPkt, outPacket);
            end
        end
        checkData("deliveries", apbData'(1), apbData'(delivered));
        apbRead(regStatus, rd, 1'b0);
        checkData("STATUS released", statusWord(1'b0), rd);
    endtask

    task automatic registerMap();
        apbData rd;
        testName = "registerMap";
        apbWrite(regCount, apbData'(5), 1'b0);
        apbRead(regCount, rd, 1'b0);
        checkData("COUNT", apbData'(5), rd);
        apbRead(regCtrl, rd, 1'b0);
        checkData("CTRL", '0, rd);
        apbWrite(8'h40, 32'hFFFF_FFFF, 1'b1);     // Unmapped
        apbRead(8'h40, rd, 1'b1);
        checkData("unmapped read", '0, rd);
        apbRead(regCount, rd, 1'b0);
        checkData("COUNT after bad write", apbData'(5), rd);
        apbRead(regStatus, rd, 1'b0);
        checkData("STATUS idle", statusWord(1'b0), rd);
    endtask

    // ==========================================================
    // Sequence
    // ==========================================================
    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        outReady = 1'b1;    // Sink always ready unless stalled
        testName = "setup";
        seed     = 32'h87a5_4297;
        for (int i = 0; i < numWords; i++) begin
            words[i] = dataWord'($random(seed));
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        resetState();
        fullPacket();
        shortPacket();
        bypassPacket();
        backPressure();
        registerMap();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- source/apbRegs.sv
// Zero-wait APB slave; commands are dropped while busy and bypass wins when both bits are set
module apbRegs (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  busPkg::apbAddr    paddr,
    input  busPkg::apbData    pwdata,
    output busPkg::apbData    prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic              busy,
    output packPkg::wordCount count,
    output logic              start,
    output logic              bypass,
    output logic              wrEn,
    output packPkg::wordAddr  wrAddr,
    output packPkg::dataWord  wrData
);
    import busPkg::*;
    import packPkg::*;

    logic     access;       // Access phase
    logic     wrAccess;
    logic     isCtrl;
    logic     isCount;
    logic     isStatus;
    logic     isWord;
    logic     mapped;
    apbAddr   wordOffset;   // Offset into the word entries
    wordCount countQ;
    logic     startQ;
    logic     bypassQ;
    logic     cmdOk;

    // ==========================================================
    // Address decode
    // ==========================================================
    assign access   = psel & penable;
    assign wrAccess = access & pwrite;

    assign isCtrl   = (paddr == regCtrl);
    assign isCount  = (paddr == regCount);
    assign isStatus = (paddr == regStatus);
    assign isWord   = (paddr >= regWordBase) && (paddr <= regWordLast)
                      && (paddr[1:0] == 2'b00);     // Aligned entries only
    assign mapped   = isCtrl | isCount | isStatus | isWord;

    assign pready  = 1'b1;                  // Never stalls
    assign pslverr = access & ~mapped;      // Unmapped access

    // Read mux, CTRL and word entries read as 0
    always_comb begin
        prdata = '0;
        if (isCount) begin
            prdata = apbData'(countQ);
        end else if (isStatus) begin
            prdata[statusBusyBit] = busy;
        end
    end

    // ==========================================================
    // Word entry writes
    // ==========================================================
    assign wordOffset = paddr - regWordBase;
    assign wrEn       = wrAccess & isWord;              // Lands on the closing edge
    assign wrAddr     = wordAddr'(wordOffset >> 2);
    assign wrData     = dataWord'(pwdata);              // Low byte

    // ==========================================================
    // COUNT and command pulses
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            countQ <= '0;
        end else if (wrAccess && isCount) begin
            countQ <= wordCount'(pwdata);
        end
    end

    // Pending pulse also blocks, busy lags it by a cycle
    assign cmdOk = wrAccess & isCtrl & ~busy & ~startQ & ~bypassQ;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            startQ  <= 1'b0;
            bypassQ <= 1'b0;
        end else begin
            startQ  <= cmdOk & pwdata[ctrlStartBit] & ~pwdata[ctrlBypassBit];
            bypassQ <= cmdOk & pwdata[ctrlBypassBit];   // Bypass wins
        end
    end

    assign count  = countQ;
    assign start  = startQ;
    assign bypass = bypassQ;

    // Host must keep psel through the access phase
    apbEnableInSel: assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel)
        else $error("apbRegs: penable high without psel");

endmodule

//--- source/busPkg.sv
// APB map for a zero-wait slave with 8-bit addresses; word entries are write only and read as 0
package busPkg;

    // ==========================================================
    // Bus widths
    // ==========================================================
    typedef logic [7:0]  apbAddr;   // Byte address, word aligned registers
    typedef logic [31:0] apbData;

    // ==========================================================
    // Register address map
    // ==========================================================
    localparam apbAddr regCtrl     = 8'h00; // Command pulses, reads 0
    localparam apbAddr regCount    = 8'h04; // Number of words minus one
    localparam apbAddr regStatus   = 8'h08; // Read only
    localparam apbAddr regWordBase = 8'h10; // Word entry 0

    // Last word entry, entries 4 apart
    localparam apbAddr regWordLast = 8'h2C;

    // ==========================================================
    // CTRL and STATUS bit positions
    // ==========================================================
    localparam int ctrlStartBit  = 0;   // Gather and pack
    localparam int ctrlBypassBit = 1;   // Zero packet, wins over start
    localparam int statusBusyBit = 0;   // Packer running or packet held

endpackage

//--- source/packOutput.sv
// Single packet holder; the packer must not finish while a packet is still held
module packOutput (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            done,
    input  packPkg::packetT packet,
    input  logic            running,
    output logic            outValid,
    input  logic            outReady,
    output packPkg::packetT outPacket,
    output logic            busy
);
    import packPkg::*;

    packetT heldQ;  // Payload, no reset
    logic   fullQ;
    logic   xfer;

    assign xfer = fullQ & outReady;     // Stream transfer this edge

    // ==========================================================
    // Occupancy
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fullQ <= 1'b0;
        end else if (done) begin
            fullQ <= 1'b1;
        end else if (xfer) begin
            fullQ <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            heldQ <= packet;
        end
    end

    assign outValid  = fullQ;
    assign outPacket = heldQ;
    assign busy      = running | fullQ;     // Blocks new commands

    // Packet must hold under back-pressure
    outStableStalled: assert property (@(posedge clk) disable iff (!rst_n)
        outValid && !outReady |=> outValid && $stable(outPacket))
        else $error("packOutput: packet changed while stalled");

    // Full holder would be overwritten
    noDoneWhenFull: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !fullQ)
        else $error("packOutput: done while holder full");

endmodule

//--- source/packPkg.sv
// Fixed sizes for an 8-word by 8-bit packet; a count k always means k+1 words
package packPkg;

    // ==========================================================
    // Datapath sizes
    // ==========================================================
    localparam int numWords  = 8;   // Max words per packet
    localparam int wordWidth = 8;

    typedef logic [wordWidth-1:0]          dataWord;
    typedef logic [$clog2(numWords)-1:0]   wordCount;   // k stands for k+1 words
    typedef logic [$clog2(numWords)-1:0]   wordAddr;    // Buffer index
    typedef logic [numWords*wordWidth-1:0] packWord;

    // ==========================================================
    // Bundles
    // ==========================================================
    typedef struct packed {
        packWord  data;     // Word 0 highest within the used bits
        wordCount count;
    } packetT;

    // Packer to buffer
    typedef struct packed {
        logic    valid;
        wordAddr addr;
    } fetchReq;

    // Buffer to packer, one cycle behind the request
    typedef struct packed {
        logic    valid;
        dataWord data;
    } fetchRsp;

    typedef enum logic {IDLE, READ} packState;

endpackage

//--- source/packTop.sv
// APB in, one packet stream out; only one packet is in flight at a time
module packTop (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  busPkg::apbAddr  paddr,
    input  busPkg::apbData  pwdata,
    output busPkg::apbData  prdata,
    output logic            pready,
    output logic            pslverr,
    output logic            outValid,
    input  logic            outReady,
    output packPkg::packetT outPacket
);
    import packPkg::*;

    wordCount count;
    logic     start;
    logic     bypass;
    logic     busy;
    logic     wrEn;
    wordAddr  wrAddr;
    dataWord  wrData;
    fetchReq  req;      // Packer to buffer
    fetchRsp  rsp;      // Buffer to packer
    logic     done;
    packetT   packet;
    logic     running;

    // Input side
    apbRegs uRegs (
        .clk(clk), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .busy(busy), .count(count), .start(start), .bypass(bypass),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

    wordBuffer uBuffer (
        .clk(clk), .rst_n(rst_n),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .req(req), .rsp(rsp)
    );

    // Processing
    wordPacker uPacker (
        .clk(clk), .rst_n(rst_n),
        .count(count), .start(start), .bypass(bypass),
        .req(req), .rsp(rsp),
        .done(done), .packet(packet), .running(running)
    );

    // Output side
    packOutput uOutput (
        .clk(clk), .rst_n(rst_n),
        .done(done), .packet(packet), .running(running),
        .outValid(outValid), .outReady(outReady), .outPacket(outPacket),
        .busy(busy)
    );

endmodule

//--- source/wordBuffer.sv
// Eight-word memory without reset; a read written in the same cycle returns the old word
module wordBuffer (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wrEn,
    input  packPkg::wordAddr wrAddr,
    input  packPkg::dataWord wrData,
    input  packPkg::fetchReq req,
    output packPkg::fetchRsp rsp
);
    import packPkg::*;

    dataWord mem [numWords];    // Contents undefined after reset
    dataWord rdDataQ;
    logic    rdValidQ;

    // Host write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // Registered read, one cycle behind the request
    always_ff @(posedge clk) begin
        if (req.valid) begin
            rdDataQ <= mem[req.addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdValidQ <= 1'b0;
        end else begin
            rdValidQ <= req.valid;  // Fixed one cycle delay
        end
    end

    assign rsp = '{valid: rdValidQ, data: rdDataQ};

endmodule

//--- source/wordPacker.sv
// Expects each response exactly one cycle after its request and never gets start while running
module wordPacker (
    input  logic              clk,
    input  logic              rst_n,
    input  packPkg::wordCount count,
    input  logic              start,
    input  logic              bypass,
    output packPkg::fetchReq  req,
    input  packPkg::fetchRsp  rsp,
    output logic              done,
    output packPkg::packetT   packet,
    output logic              running
);
    import packPkg::*;

    packState state;
    packState nextState;
    wordCount countQ;   // Latched at start, host may rewrite COUNT
    wordAddr  reqCnt;   // Next address to request
    logic     reqOpen;  // Requests still to issue
    wordAddr  rxCnt;    // Words received so far
    logic     lastRx;
    logic     doneQ;
    packWord  shiftQ;

    assign lastRx = rsp.valid && (rxCnt == countQ);

    // ==========================================================
    // State machine
    // ==========================================================
    always_comb begin
        nextState = state;
        case (state)
            IDLE:    if (start) nextState = READ;
            READ:    if (lastRx) nextState = IDLE;  // All words in
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // ==========================================================
    // Request side, runs ahead of responses
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reqOpen <= 1'b0;
            reqCnt  <= '0;
        end else if (start) begin
            reqOpen <= 1'b1;
            reqCnt  <= '0;
        end else if (reqOpen) begin
            reqCnt  <= reqCnt + 1'b1;
            reqOpen <= (reqCnt != countQ);  // Close after count+1 issues
        end
    end

    assign req = '{valid: reqOpen, addr: reqCnt};

    // ==========================================================
    // Receive side and done
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxCnt  <= '0;
            countQ <= '0;
            doneQ  <= 1'b0;
        end else begin
            doneQ <= lastRx | bypass;   // Cycle after last word, or straight after bypass
            if (start) begin
                rxCnt  <= '0;
                countQ <= count;
            end else if (bypass) begin
                countQ <= '0;
            end else if (rsp.valid) begin
                rxCnt <= rxCnt + 1'b1;
            end
        end
    end

    // Shift left, newest word at the bottom
    always_ff @(posedge clk) begin
        if (start || bypass) begin
            shiftQ <= '0;
        end else if (rsp.valid) begin
            shiftQ <= {shiftQ[$bits(packWord)-wordWidth-1:0], rsp.data};
        end
    end

    assign done    = doneQ;
    assign packet  = '{data: shiftQ, count: countQ};
    assign running = (state == READ) | doneQ;   // Covers the done cycle too

    // Buffer must not answer outside a fetch
    rspOnlyInRead: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.valid |-> state == READ)
        else $error("wordPacker: response while idle");

    // Register block gates commands on busy
    startOnlyInIdle: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> state == IDLE)
        else $error("wordPacker: start while reading");

endmodule
